//--- list.f
+incdir+include
source/dma_ctrl_pkg.sv
source/dma_stream_regs.sv
source/dma_route_table.sv
source/dma_ctrl.sv
source/dma_ctrl_top.sv
verification/dma_ctrl_tb.sv

//--- include/dma_ctrl_tb_model.svh
// Reference model of the stream registers, counters and route table
// Included inside the testbench module

`ifndef DMA_CTRL_TB_MODEL_SVH
`define DMA_CTRL_TB_MODEL_SVH

logic                      m_enabled   [dma_ctrl_pkg::num_streams];
logic                      m_buf_64    [dma_ctrl_pkg::num_streams];
dma_ctrl_pkg::frame_size_t m_fsize     [dma_ctrl_pkg::num_streams];
logic [31:0]               m_samp_cnt  [dma_ctrl_pkg::num_streams];
logic [31:0]               m_pkt_cnt   [dma_ctrl_pkg::num_streams];
dma_ctrl_pkg::dst_t        m_route     [1 << dma_ctrl_pkg::rtr_sid_w];

function automatic void model_reset();
    for (int s = 0; s < dma_ctrl_pkg::num_streams; s++) begin
        m_enabled[s]  = 1'b0;
        m_buf_64[s]   = 1'b1;
        m_fsize[s]    = dma_ctrl_pkg::default_fsize;
        m_samp_cnt[s] = '0;
        m_pkt_cnt[s]  = '0;
    end
    foreach (m_route[k]) m_route[k] = '0;
endfunction

// One clock edge: strobes count first, a clear write then overrides them
function automatic void model_cycle(input logic wr, input dma_ctrl_pkg::addr_t addr,
                                    input logic [31:0] data, input logic [3:0] samp,
                                    input logic [3:0] pkt);
    int s;
    for (int i = 0; i < dma_ctrl_pkg::num_streams; i++) begin
        m_samp_cnt[i] += samp[i];
        m_pkt_cnt[i]  += pkt[i];
    end
    s = addr[5:4];
    if (wr && addr[19:6] == dma_ctrl_pkg::reg_base_addr[19:6]) begin
        case (addr[3:0])
            dma_ctrl_pkg::reg_ctrl_status: begin
                m_enabled[s] = data[1];
                m_buf_64[s]  = data[4];
            end
            dma_ctrl_pkg::reg_fsize:    m_fsize[s]    = data[15:0];
            dma_ctrl_pkg::reg_samp_cnt: m_samp_cnt[s] = '0;
            dma_ctrl_pkg::reg_pkt_cnt:  m_pkt_cnt[s]  = '0;
            default: ;
        endcase
    end
    if (wr && (addr & dma_ctrl_pkg::rtr_addr_mask) == dma_ctrl_pkg::rtr_base_addr) begin
        m_route[addr[7:0]] = data[1:0];
    end
endfunction

// Expected read data for an address, given the live status inputs
function automatic logic [31:0] model_read(input dma_ctrl_pkg::addr_t addr,
                                           input logic [3:0] busy, input logic [3:0] err);
    int s;
    s = addr[5:4];
    if (addr[19:6] != dma_ctrl_pkg::reg_base_addr[19:6]) return '1;
    case (addr[3:0])
        dma_ctrl_pkg::reg_ctrl_status: return {30'h0, busy[s], err[s]};
        dma_ctrl_pkg::reg_fsize:       return 32'(m_fsize[s]);
        dma_ctrl_pkg::reg_samp_cnt:    return m_samp_cnt[s];
        dma_ctrl_pkg::reg_pkt_cnt:     return m_pkt_cnt[s];
        default:                       return '1;
    endcase
endfunction

`endif

//--- verification/dma_ctrl_tb.sv
// Testbench for the DMA register block with a reference model
// Random register, counter, status, route and back-pressure tests

module dma_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import dma_ctrl_pkg::*;

    localparam int wait_limit = 50;     // Cycles before a wait gives up

    logic                          clk;
    logic                          reset;
    dma_msg_t                      regi_tdata;
    dma_msg_t                      rego_tdata;
    logic                          regi_tvalid, regi_tready, rego_tvalid, rego_tready;
    logic [num_streams-1:0]        set_enabled, set_clear;
    frame_size_t [num_streams-1:0] set_frame_size;
    logic [num_streams-1:0][2:0]   swap_lanes;
    logic [num_streams-1:0]        packet_stb, sample_stb, stream_busy, stream_err;
    sid_t                          rtr_sid;
    dst_t                          rtr_dst;

    logic [31:0] lfsr_state = 32'h9b3e_0062;
    int          checks = 0;
    int          errors = 0;
    int          test_errs;             // Error count when the running test began
    string       cur_test;

    `include "dma_ctrl_tb_model.svh"

    dma_ctrl_top u_dma_ctrl_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Model sees the same inputs as the DUT at each edge
    always @(posedge clk) begin
        if (reset) begin
            model_reset();
        end else begin
            model_cycle(regi_tvalid && regi_tdata.req.wr, regi_tdata.req.addr,
                        regi_tdata.req.payload, sample_stb, packet_stb);
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic dma_msg_t make_req(input logic wr, input logic rd, input addr_t addr,
                                          input logic [31:0] payload);
        dma_msg_t m;
        m             = '0;
        m.req.wr      = wr;
        m.req.rd      = rd;
        m.req.addr    = addr;
        m.req.payload = payload;
        return m;
    endfunction

    function automatic addr_t reg_addr(input int s, input logic [3:0] off);
        return reg_base_addr | addr_t'({chan_w'(s), off});
    endfunction

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_frame(input string what, input frame_size_t exp, input frame_size_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_dst(input string what, input dst_t exp, input dst_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bits(input string what, input logic [num_streams-1:0] exp,
                              input logic [num_streams-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_lanes(input string what, input logic [num_streams-1:0][2:0] exp,
                               input logic [num_streams-1:0][2:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic wait_timeout(input string what);
        $display("Timed out waiting for %s in test %s", what, cur_test);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic finish_test();
        $display("Test %s done with %0d errors", cur_test, errors - test_errs);
    endtask

    // Write with optional counter strobes in the accepting cycle
    task automatic bus_write(input addr_t addr, input logic [31:0] data,
                             input logic [num_streams-1:0] samp,
                             input logic [num_streams-1:0] pkt);
        int n;
        @(posedge clk);
        regi_tdata  <= make_req(1'b1, 1'b0, addr, data);
        regi_tvalid <= 1'b1;
        sample_stb  <= samp;
        packet_stb  <= pkt;
        n = 0;
        @(negedge clk);
        while (!regi_tready) begin
            if (n == wait_limit) wait_timeout("write accept");
            n++;
            @(negedge clk);
        end
        @(posedge clk);                 // Accepting edge
        regi_tvalid <= 1'b0;
        sample_stb  <= '0;
        packet_stb  <= '0;
    endtask

    task automatic read_check(input addr_t addr);
        int n;
        @(posedge clk);
        regi_tdata  <= make_req(1'b0, 1'b1, addr, '0);
        regi_tvalid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!(rego_tvalid && regi_tready)) begin
            if (n == wait_limit) wait_timeout("read response");
            n++;
            @(negedge clk);
        end
        check_flag("response flag", 1'b1, rego_tdata.rsp.resp);
        check_word($sformatf("read %h", addr), model_read(addr, stream_busy, stream_err),
                   rego_tdata.rsp.data);
        @(posedge clk);
        regi_tvalid <= 1'b0;
    endtask

    task automatic read_counters();
        for (int s = 0; s < num_streams; s++) begin
            read_check(reg_addr(s, reg_samp_cnt));
            read_check(reg_addr(s, reg_pkt_cnt));
        end
    endtask

    // Settings outputs against the model, 100 for a 32-bit buffer
    task automatic check_settings();
        logic [num_streams-1:0]      exp_en;
        logic [num_streams-1:0][2:0] exp_lanes;
        for (int s = 0; s < num_streams; s++) begin
            exp_en[s]    = m_enabled[s];
            exp_lanes[s] = m_buf_64[s] ? 3'b000 : 3'b100;
            check_frame($sformatf("frame size %0d", s), m_fsize[s], set_frame_size[s]);
        end
        check_bits("enable", exp_en, set_enabled);
        check_lanes("swap lanes", exp_lanes, swap_lanes);
    endtask

    initial begin
        int                     s;
        int                     n;
        logic [31:0]            data;
        logic [31:0]            held;
        logic [3:0]             off;
        addr_t                  addr;
        logic [num_streams-1:0] one_hot;
        reset       = 1'b1;
        regi_tdata  = '0;
        regi_tvalid = 1'b0;
        rego_tready = 1'b1;
        packet_stb  = '0;
        sample_stb  = '0;
        stream_busy = '0;
        stream_err  = '0;
        rtr_sid     = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Reset values, then random settings writes
        cur_test  = "reset_readback";
        test_errs = errors;
        @(negedge clk);
        check_bits("enable after reset", '0, set_enabled);
        check_bits("clear after reset", '0, set_clear);
        check_flag("rego_tvalid after reset", 1'b0, rego_tvalid);
        check_frame("frame size after reset", 16'd32, set_frame_size[0]);
        check_settings();
        for (int i = 0; i < num_streams; i++) begin
            for (int o = 0; o < 4; o++) read_check(reg_addr(i, 4'(o * 4)));
        end
        repeat (10) begin
            s    = int'(rand_bits(2));
            data = rand_bits(32);
            if (rand_bits(1) == 1) bus_write(reg_addr(s, reg_ctrl_status), data, '0, '0);
            else bus_write(reg_addr(s, reg_fsize), data, '0, '0);
            @(negedge clk);
            check_settings();
            read_check(reg_addr(s, reg_fsize));
        end
        finish_test();

        cur_test  = "clear_pulse";
        test_errs = errors;
        for (int i = 0; i < num_streams; i++) begin
            data    = rand_bits(32) | 32'h1;
            one_hot = num_streams'(1) << i;
            bus_write(reg_addr(i, reg_ctrl_status), data, '0, '0);
            @(negedge clk);
            check_bits("clear pulse", one_hot, set_clear);
            @(negedge clk);
            check_bits("clear drop", '0, set_clear);    // Exactly one cycle
        end
        finish_test();

        cur_test  = "counters";
        test_errs = errors;
        n = int'(rand_bits(5)) + 1;
        repeat (n) begin
            @(posedge clk);
            sample_stb <= num_streams'(rand_bits(num_streams));
            packet_stb <= num_streams'(rand_bits(num_streams));
        end
        @(posedge clk);
        sample_stb <= '0;
        packet_stb <= '0;
        read_counters();
        s = int'(rand_bits(2));
        bus_write(reg_addr(s, reg_samp_cnt), '0, '1, '1);   // Clear beats the strobe
        read_counters();
        s = int'(rand_bits(2));
        bus_write(reg_addr(s, reg_pkt_cnt), '0, '1, '1);
        read_counters();
        finish_test();

        cur_test  = "status_invalid";
        test_errs = errors;
        repeat (3) begin
            @(posedge clk);
            stream_busy <= num_streams'(rand_bits(num_streams));
            stream_err  <= num_streams'(rand_bits(num_streams));
            for (int i = 0; i < num_streams; i++) read_check(reg_addr(i, reg_ctrl_status));
        end
        repeat (6) begin
            off = 4'(rand_bits(4));
            if (off[1:0] == 2'b00) off[0] = 1'b1;
            s = int'(rand_bits(2));
            read_check(reg_addr(s, off));
        end
        repeat (6) begin
            addr = addr_t'(rand_bits(20));
            if (addr[19:6] == '0) addr[19] = 1'b1;
            read_check(addr);
        end
        read_check(rtr_base_addr);      // Route window reads back all ones
        finish_test();

        cur_test  = "route_table";
        test_errs = errors;
        repeat (16) begin
            addr = rtr_base_addr | addr_t'(rand_bits(rtr_sid_w));
            data = rand_bits(32);
            bus_write(addr, data, '0, '0);
        end
        for (int k = 0; k < (1 << rtr_sid_w); k++) begin
            @(posedge clk);
            rtr_sid <= sid_t'(k);
            @(negedge clk);
            check_dst($sformatf("route %0d", k), m_route[k], rtr_dst);
        end
        finish_test();

        // Read held with rego_tready low, then a write slips through
        cur_test  = "back_pressure";
        test_errs = errors;
        s = int'(rand_bits(2));
        n = int'(rand_bits(3)) + 1;
        @(posedge clk);
        regi_tdata  <= make_req(1'b0, 1'b1, reg_addr(s, reg_fsize), '0);
        regi_tvalid <= 1'b1;
        rego_tready <= 1'b0;
        @(negedge clk);
        held = rego_tdata.rsp.data;
        check_word("held data", model_read(reg_addr(s, reg_fsize), stream_busy, stream_err), held);
        repeat (n) begin
            check_flag("regi_tready stalled", 1'b0, regi_tready);
            check_flag("rego_tvalid held", 1'b1, rego_tvalid);
            @(negedge clk);
            check_word("stable data", held, rego_tdata.rsp.data);
        end
        data = rand_bits(32);
        @(posedge clk);
        regi_tdata <= make_req(1'b1, 1'b0, reg_addr(s, reg_fsize), data);
        @(negedge clk);
        check_flag("write ready", 1'b1, regi_tready);
        @(posedge clk);
        regi_tvalid <= 1'b0;
        rego_tready <= 1'b1;
        @(negedge clk);
        check_settings();
        read_check(reg_addr(s, reg_fsize));
        finish_test();

        $display("Done with %0d checks and %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- source/dma_ctrl_top.sv
// Top level of the DMA register block
// Joins the register controller and the route table to the outside ports

module dma_ctrl_top (
    input  logic                   clk,
    input  logic                   reset,

    input  dma_ctrl_pkg::dma_msg_t regi_tdata,
    input  logic                   regi_tvalid,
    output logic                   regi_tready,
    output dma_ctrl_pkg::dma_msg_t rego_tdata,
    output logic                   rego_tvalid,
    input  logic                   rego_tready,

    output logic [dma_ctrl_pkg::num_streams-1:0]                      set_enabled,
    output logic [dma_ctrl_pkg::num_streams-1:0]                      set_clear,
    output dma_ctrl_pkg::frame_size_t [dma_ctrl_pkg::num_streams-1:0]  set_frame_size,
    output logic [dma_ctrl_pkg::num_streams-1:0][2:0]                 swap_lanes,

    input  logic [dma_ctrl_pkg::num_streams-1:0]                      packet_stb,
    input  logic [dma_ctrl_pkg::num_streams-1:0]                      sample_stb,
    input  logic [dma_ctrl_pkg::num_streams-1:0]                      stream_busy,
    input  logic [dma_ctrl_pkg::num_streams-1:0]                      stream_err,

    input  dma_ctrl_pkg::sid_t     rtr_sid,
    output dma_ctrl_pkg::dst_t     rtr_dst
);

    dma_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .regi_tdata     (regi_tdata),
        .regi_tvalid    (regi_tvalid),
        .regi_tready    (regi_tready),
        .rego_tdata     (rego_tdata),
        .rego_tvalid    (rego_tvalid),
        .rego_tready    (rego_tready),
        .set_enabled    (set_enabled),
        .set_clear      (set_clear),
        .set_frame_size (set_frame_size),
        .swap_lanes     (swap_lanes),
        .packet_stb     (packet_stb),
        .sample_stb     (sample_stb),
        .stream_busy    (stream_busy),
        .stream_err     (stream_err)
    );

    // Route table snoops the same request stream
    dma_route_table u_route (
        .clk         (clk),
        .reset       (reset),
        .regi_tdata  (regi_tdata),
        .regi_tvalid (regi_tvalid),
        .rtr_sid     (rtr_sid),
        .rtr_dst     (rtr_dst)
    );

endmodule

//--- source/dma_ctrl.sv
// Host message decode and per-stream write strobes for the DMA register block
// Holds the stream register array, the readback select and the valid/ready handshake

module dma_ctrl (
    input  logic                   clk,
    input  logic                   reset,

    // Host register port
    input  dma_ctrl_pkg::dma_msg_t regi_tdata,
    input  logic                   regi_tvalid,
    output logic                   regi_tready,
    output dma_ctrl_pkg::dma_msg_t rego_tdata,
    output logic                   rego_tvalid,
    input  logic                   rego_tready,

    // Stream settings
    output logic [dma_ctrl_pkg::num_streams-1:0]                            set_enabled,
    output logic [dma_ctrl_pkg::num_streams-1:0]                            set_clear,
    output dma_ctrl_pkg::frame_size_t [dma_ctrl_pkg::num_streams-1:0]        set_frame_size,
    output logic [dma_ctrl_pkg::num_streams-1:0][2:0]                       swap_lanes,

    // Stream events and state
    input  logic [dma_ctrl_pkg::num_streams-1:0]                            packet_stb,
    input  logic [dma_ctrl_pkg::num_streams-1:0]                            sample_stb,
    input  logic [dma_ctrl_pkg::num_streams-1:0]                            stream_busy,
    input  logic [dma_ctrl_pkg::num_streams-1:0]                            stream_err
);

    import dma_ctrl_pkg::*;

    addr_t                 addr;
    logic [31:0]           payload;
    logic                  wr_req;
    logic                  rd_req;
    logic                  in_block;        // Address hits the stream register block
    logic [chan_w-1:0]     chan;
    logic [reg_grp_w-1:0]  offset;
    logic                  offset_ok;
    logic [31:0]           rd_word [num_streams];

    // Request view of the incoming word
    assign addr    = regi_tdata.req.addr;
    assign payload = regi_tdata.req.payload;
    assign wr_req  = regi_tvalid && regi_tdata.req.wr;
    assign rd_req  = regi_tvalid && regi_tdata.req.rd;

    // Block is aligned, so the upper address bits must match the base
    assign in_block = addr[$bits(addr_t)-1:chan_w+reg_grp_w]
                   == reg_base_addr[$bits(addr_t)-1:chan_w+reg_grp_w];
    assign chan     = addr[chan_w+reg_grp_w-1:reg_grp_w];
    assign offset   = addr[reg_grp_w-1:0];

    assign offset_ok = (offset == reg_ctrl_status) || (offset == reg_fsize)
                    || (offset == reg_samp_cnt) || (offset == reg_pkt_cnt);

    for (genvar i = 0; i < num_streams; i++) begin : g_stream
        logic ch_wr;

        assign ch_wr = wr_req && in_block && (chan == chan_w'(i));

        dma_stream_regs u_regs (
            .clk            (clk),
            .reset          (reset),
            .wr_ctrl        (ch_wr && (offset == reg_ctrl_status)),
            .wr_fsize       (ch_wr && (offset == reg_fsize)),
            .clr_samp       (ch_wr && (offset == reg_samp_cnt)),
            .clr_pkt        (ch_wr && (offset == reg_pkt_cnt)),
            .wr_data        (payload),
            .rd_sel         (offset[3:2]),
            .packet_stb     (packet_stb[i]),
            .sample_stb     (sample_stb[i]),
            .stream_busy    (stream_busy[i]),
            .stream_err     (stream_err[i]),
            .set_enabled    (set_enabled[i]),
            .set_clear      (set_clear[i]),
            .set_frame_size (set_frame_size[i]),
            .swap_lanes     (swap_lanes[i]),
            .rd_data        (rd_word[i])
        );
    end

    // Response view of the outgoing word
    always_comb begin
        rego_tdata          = '0;
        rego_tdata.rsp.resp = 1'b1;
        if (in_block && offset_ok) begin
            rego_tdata.rsp.data = rd_word[chan];
        end else begin
            rego_tdata.rsp.data = '1;           // Unmapped reads return all ones
        end
    end

    // Reads answer in the same cycle, writes never wait
    assign rego_tvalid = rd_req;
    assign regi_tready = rego_tready || wr_req;

endmodule

//--- source/dma_route_table.sv
// Route table mapping a local stream id to a FIFO destination
// Written through its own address window on the host bus

module dma_route_table (
    input  logic                   clk,
    input  logic                   reset,

    // Incoming host requests, watched passively
    input  dma_ctrl_pkg::dma_msg_t regi_tdata,
    input  logic                   regi_tvalid,

    // Lookup port
    input  dma_ctrl_pkg::sid_t     rtr_sid,
    output dma_ctrl_pkg::dst_t     rtr_dst
);

    import dma_ctrl_pkg::*;

    dst_t  route_mem [1 << rtr_sid_w];  // One destination per stream id

    logic  in_window;
    logic  route_wr;
    sid_t  wr_idx;
    dst_t  wr_dst;

    // Address decode of the route window
    assign in_window = (regi_tdata.req.addr & rtr_addr_mask) == rtr_base_addr;
    assign route_wr  = regi_tvalid && regi_tdata.req.wr && in_window;

    assign wr_idx = regi_tdata.req.addr[rtr_sid_w-1:0];         // Low address bits pick the entry
    assign wr_dst = regi_tdata.req.payload[rtr_dst_w-1:0];

    // Table update
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < (1 << rtr_sid_w); k++) begin
                route_mem[k] <= '0;
            end
        end else if (route_wr) begin
            route_mem[wr_idx] <= wr_dst;
        end
    end

    // Lookup has no latency
    assign rtr_dst = route_mem[rtr_sid];

endmodule

//--- source/dma_stream_regs.sv
// Settings registers, sample and packet counters and readback word of one DMA stream

module dma_stream_regs (
    input  logic                      clk,
    input  logic                      reset,

    // Write strobes per register offset
    input  logic                      wr_ctrl,
    input  logic                      wr_fsize,
    input  logic                      clr_samp,
    input  logic                      clr_pkt,
    input  logic [31:0]               wr_data,
    input  logic [1:0]                rd_sel,

    // Stream side
    input  logic                      packet_stb,
    input  logic                      sample_stb,
    input  logic                      stream_busy,
    input  logic                      stream_err,

    output logic                      set_enabled,
    output logic                      set_clear,
    output dma_ctrl_pkg::frame_size_t set_frame_size,
    output logic [2:0]                swap_lanes,
    output logic [31:0]               rd_data
);

    import dma_ctrl_pkg::*;

    logic        buf_is_64;     // Software buffer width, 1 selects 64-bit
    logic [31:0] samp_count;
    logic [31:0] pkt_count;

    // Control and frame size settings
    always_ff @(posedge clk) begin
        if (reset) begin
            set_enabled    <= 1'b0;
            set_clear      <= 1'b0;
            buf_is_64      <= 1'b1;
            set_frame_size <= default_fsize;
        end else begin
            set_clear <= wr_ctrl && wr_data[0];     // Pulse lasts one cycle only
            if (wr_ctrl) begin
                set_enabled <= wr_data[1];
                buf_is_64   <= wr_data[4];          // Bits 5:4 hold the buffer size code
            end
            if (wr_fsize) begin
                set_frame_size <= wr_data[frame_size_w-1:0];
            end
        end
    end

    // Only the 32 and 64 bit modes remain, so one bit decides the swap
    assign swap_lanes = {~buf_is_64, 2'b00};

    // Sample counter, a clear write beats a strobe
    always_ff @(posedge clk) begin
        if (reset || clr_samp) begin
            samp_count <= '0;
        end else if (sample_stb) begin
            samp_count <= samp_count + 32'd1;
        end
    end

    // Packet counter
    always_ff @(posedge clk) begin
        if (reset || clr_pkt) begin
            pkt_count <= '0;
        end else if (packet_stb) begin
            pkt_count <= pkt_count + 32'd1;
        end
    end

    // Readback for the addressed offset
    always_comb begin
        case (rd_sel)
            2'd0:    rd_data = {30'h0, stream_busy, stream_err};
            2'd1:    rd_data = 32'(set_frame_size);
            2'd2:    rd_data = samp_count;
            default: rd_data = pkt_count;
        endcase
    end

endmodule

//--- source/dma_ctrl_pkg.sv
// Shared sizes, register map and reset values of the DMA register block
// Host message word with its request and response views

package dma_ctrl_pkg;

    localparam int num_streams  = 4;
    localparam int chan_w       = 2;    // Stream index width
    localparam int frame_size_w = 16;
    localparam int reg_grp_w    = 4;    // Address bits inside one stream group

    typedef logic [19:0]             addr_t;
    typedef logic [frame_size_w-1:0] frame_size_t;

    localparam addr_t reg_base_addr = 20'h00000;

    // In-group register offsets
    localparam logic [reg_grp_w-1:0] reg_ctrl_status = 4'h0; // R status, W control
    localparam logic [reg_grp_w-1:0] reg_fsize       = 4'h4;
    localparam logic [reg_grp_w-1:0] reg_samp_cnt    = 4'h8; // W clears the count
    localparam logic [reg_grp_w-1:0] reg_pkt_cnt     = 4'hC; // W clears the count

    localparam frame_size_t default_fsize = 16'd32;

    // Route table window sits right above the stream block
    localparam int rtr_sid_w = 8;
    localparam int rtr_dst_w = 2;

    typedef logic [rtr_sid_w-1:0] sid_t;
    typedef logic [rtr_dst_w-1:0] dst_t;

    localparam addr_t rtr_base_addr = reg_base_addr + addr_t'(1 << rtr_sid_w);
    localparam addr_t rtr_addr_mask = 20'hFFFFF ^ addr_t'((1 << rtr_sid_w) - 1);

    typedef struct packed {
        logic        wr;        // Write request
        logic        rd;        // Read request
        logic        resp;      // Response flag
        logic [8:0]  pad;
        addr_t       addr;
        logic [31:0] payload;
    } dma_req_t;

    typedef struct packed {
        logic        wr;
        logic        rd;
        logic        resp;
        logic [28:0] pad;
        logic [31:0] data;      // Read data
    } dma_rsp_t;

    typedef union packed {
        dma_req_t req;
        dma_rsp_t rsp;
    } dma_msg_t;

endpackage
